// File: rtl/div_approx_macros.svh
`ifndef DIV_APPROX_MACROS_SVH
`define DIV_APPROX_MACROS_SVH

// datapath widths.
`define DIV_N_W 16
`define DIV_D_W 8

// cells with column plus row below this depth may run approximate.
`define DIV_APPROX_DEPTH 6

// result storage, also the limit on operations in flight.
`define DIV_FIFO_DEPTH 8
`define DIV_CNT_W 4

// apb register offsets.
`define DIV_ADDR_OPERAND 4'h0
`define DIV_ADDR_CTRL 4'h4
`define DIV_ADDR_RESULT 4'h8
`define DIV_ADDR_STATUS 4'hC

`endif

// File: rtl/div_pkg.sv
`include "div_approx_macros.svh"

package div_pkg;

  // register map.
  typedef enum logic [3:0] {
    ADDR_OPERAND = `DIV_ADDR_OPERAND,
    ADDR_CTRL    = `DIV_ADDR_CTRL,
    ADDR_RESULT  = `DIV_ADDR_RESULT,
    ADDR_STATUS  = `DIV_ADDR_STATUS
  } div_addr_e;

  // one division as it moves down the array.
  typedef struct packed {
    logic [`DIV_N_W-1:0] dividend;
    logic [`DIV_D_W-1:0] divisor;
    logic [`DIV_D_W-1:0] prem;       // partial remainder.
    logic [`DIV_D_W-1:0] quo;        // quotient bits resolved so far.
    logic                approx_en;  // mode picked at launch.
  } div_op_t;

endpackage

// File: rtl/div_stage_if.sv
`timescale 1ns/1ps

interface div_stage_if
  import div_pkg::*;
(
  input logic clk,
  input logic rst_n
);

  logic    valid;
  div_op_t op;

  // no ready, the next stage always takes the payload.
  modport src (
    input  clk,
    input  rst_n,
    output valid,
    output op
  );

  modport dst (
    input clk,
    input rst_n,
    input valid,
    input op
  );

endinterface

// File: rtl/div_apb_regs.sv
`timescale 1ns/1ps
`include "div_approx_macros.svh"

module div_apb_regs
  import div_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  div_stage_if.src    launch,
  output logic        rd_pop,
  input  div_op_t     fifo_head,
  input  logic        fifo_valid,
  input  logic [3:0]  fifo_count
);

  div_addr_e             addr;
  div_op_t               first_op;
  logic                  access;
  logic                  mapped;
  logic                  credits_full;
  logic                  wr_operand;
  logic                  wr_ctrl;
  logic                  approx_en;
  logic [`DIV_CNT_W-1:0] credits;
  logic [`DIV_CNT_W-1:0] in_flight;

  assign addr   = div_addr_e'(paddr);
  assign access = psel & penable;

  always_comb begin
    case (addr)
      ADDR_OPERAND, ADDR_CTRL, ADDR_RESULT, ADDR_STATUS: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  // every slot taken by the array or the fifo.
  assign credits_full = (credits == `DIV_CNT_W'(`DIV_FIFO_DEPTH));

  // an operand write waits here until a result read frees a slot.
  assign pready  = ~(access & pwrite & (addr == ADDR_OPERAND) & credits_full);
  assign pslverr = access & ~mapped;

  assign wr_operand = access & pwrite & (addr == ADDR_OPERAND) & ~credits_full;
  assign wr_ctrl    = access & pwrite & (addr == ADDR_CTRL);
  assign rd_pop     = access & ~pwrite & (addr == ADDR_RESULT) & fifo_valid;

  assign in_flight = credits - fifo_count;  // ops still in the rows.

  always_comb begin
    prdata = '0;
    if (psel & ~pwrite) begin
      case (addr)
        ADDR_CTRL: prdata[0] = approx_en;
        ADDR_RESULT: begin
          if (fifo_valid) begin
            prdata[16:0] = {1'b1, fifo_head.prem, fifo_head.quo};
          end
        end
        ADDR_STATUS: prdata[7:0] = {in_flight, fifo_count};
        default: prdata = '0;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      approx_en <= 1'b1;
    end else if (wr_ctrl) begin
      approx_en <= pwdata[0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= '0;
    end else begin
      case ({wr_operand, rd_pop})
        2'b10: credits <= credits + 1'b1;
        2'b01: credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  // partial remainder and quotient start at zero.
  always_comb begin
    first_op           = '0;
    first_op.dividend  = pwdata[`DIV_N_W-1:0];
    first_op.divisor   = pwdata[`DIV_N_W +: `DIV_D_W];
    first_op.approx_en = approx_en;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      launch.valid <= 1'b0;
    end else begin
      launch.valid <= wr_operand;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_operand) begin
      launch.op <= first_op;
    end
  end

endmodule

// File: rtl/div_row.sv
`timescale 1ns/1ps
`include "div_approx_macros.svh"

module div_row
  import div_pkg::*;
#(
  parameter int ROW = 7
) (
  input  logic     clk,
  input  logic     rst_n,
  div_stage_if.dst up,
  div_stage_if.src down
);

  div_op_t             op_in;
  div_op_t             op_next;
  logic [`DIV_D_W-1:0] x;
  logic [`DIV_D_W-1:0] y;
  logic [`DIV_D_W-1:0] r_next;
  logic                top;
  logic                q_bit;
  wire  [`DIV_D_W-1:0] diff;
  wire  [`DIV_D_W:0]   borrow;

  assign op_in = up.op;
  assign y     = op_in.divisor;

  // minuend for this row.
  if (ROW == `DIV_D_W - 1) begin : g_first
    assign x   = op_in.dividend[`DIV_N_W-2 -: `DIV_D_W];
    assign top = op_in.dividend[`DIV_N_W-1];
  end else begin : g_next
    assign x   = {op_in.prem[`DIV_D_W-2:0], op_in.dividend[ROW]};
    assign top = op_in.prem[`DIV_D_W-1];
  end

  assign borrow[0] = 1'b0;

  for (genvar j = 0; j < `DIV_D_W; j++) begin : g_cell
    wire approx;
    wire xb;
    wire yb;
    wire bin;

    if (j + ROW < `DIV_APPROX_DEPTH) begin : g_corner
      assign approx = op_in.approx_en;
    end else begin : g_exact
      assign approx = 1'b0;
    end

    assign xb  = x[j];
    assign yb  = y[j];
    assign bin = borrow[j];

    // approximate cell drops some borrow and difference terms.
    assign borrow[j+1] = approx ? (yb & ~(xb & bin))
                                : ((~xb & yb) | (~(xb ^ yb) & bin));
    assign diff[j]     = approx ? ((xb & ~yb) | (~xb & yb & bin) | (xb & yb & ~bin))
                                : (xb ^ yb ^ bin);
  end

  // subtract succeeds when there is a carried-out top bit or no borrow.
  assign q_bit  = top | ~borrow[`DIV_D_W];
  assign r_next = q_bit ? diff : x;

  always_comb begin
    op_next          = op_in;
    op_next.prem     = r_next;
    op_next.quo[ROW] = q_bit;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      down.valid <= 1'b0;
    end else begin
      down.valid <= up.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (up.valid) begin
      down.op <= op_next;
    end
  end

endmodule

// File: rtl/div_result_fifo.sv
`timescale 1ns/1ps
`include "div_approx_macros.svh"

module div_result_fifo
  import div_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  div_stage_if.dst              tail,
  input  logic                  rd_pop,
  output div_op_t               head,
  output logic                  head_valid,
  output logic [`DIV_CNT_W-1:0] count
);

  localparam int PTR_W = $clog2(`DIV_FIFO_DEPTH);

  div_op_t          mem [`DIV_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             push;
  logic             pop;

  // credits keep the array from pushing into a full buffer.
  assign push = tail.valid;
  assign pop  = rd_pop & head_valid;

  assign head       = mem[rd_ptr];
  assign head_valid = (count != '0);

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= tail.op;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`DIV_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`DIV_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;  // both or neither.
      endcase
    end
  end

endmodule

// File: rtl/approx_div_top.sv
`timescale 1ns/1ps
`include "div_approx_macros.svh"

module approx_div_top
  import div_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  div_op_t               fifo_head;
  logic                  fifo_valid;
  logic [`DIV_CNT_W-1:0] fifo_count;
  logic                  rd_pop;

  // stage_if[8] is the launch, stage_if[0] feeds the fifo.
  div_stage_if stage_if [`DIV_D_W+1] (.clk(clk), .rst_n(rst_n));

  div_apb_regs div_apb_regs_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .launch     (stage_if[`DIV_D_W]),
    .rd_pop     (rd_pop),
    .fifo_head  (fifo_head),
    .fifo_valid (fifo_valid),
    .fifo_count (fifo_count)
  );

  for (genvar k = 0; k < `DIV_D_W; k++) begin : g_row
    div_row #(.ROW(k)) div_row_i (
      .clk   (clk),
      .rst_n (rst_n),
      .up    (stage_if[k+1]),
      .down  (stage_if[k])
    );
  end

  div_result_fifo div_result_fifo_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .tail       (stage_if[0]),
    .rd_pop     (rd_pop),
    .head       (fifo_head),
    .head_valid (fifo_valid),
    .count      (fifo_count)
  );

endmodule

// File: dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD     = 20.0,
  parameter int  RST_CYCLES = 5
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2.0) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;  // released off the edge.
  end

endmodule

// File: dv/tb_approx_div.sv
`timescale 1ns/1ps
`include "div_approx_macros.svh"

module tb_approx_div;

  localparam int APB_TIMEOUT  = 64;
  localparam int POLL_LIMIT   = 100;
  localparam int STALL_CYCLES = 20;
  localparam int DRAIN_LIMIT  = 20;

  logic        clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] seed;
  logic [15:0] exp_q[$];  // {remainder, quotient} in launch order.
  logic [16:0] got_q[$];  // raw RESULT reads.
  logic [16:0] cmp_got;
  logic [15:0] cmp_exp;

  tb_clk_gen clk_gen_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  approx_div_top approx_div_top_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // one quotient bit per row from the msb down.
  function automatic logic [15:0] ref_divide(input logic [15:0] dividend,
                                             input logic [7:0] divisor,
                                             input logic approx_en);
    logic [7:0] prem;
    logic [7:0] quo;
    logic [7:0] x;
    logic [7:0] diff;
    logic       top;
    logic       b;
    logic       q;
    logic       xb;
    logic       yb;
    prem = '0;
    quo  = '0;
    for (int k = 7; k >= 0; k--) begin
      if (k == 7) begin
        x   = dividend[14:7];
        top = dividend[15];
      end else begin
        x   = {prem[6:0], dividend[k]};
        top = prem[7];
      end
      b = 1'b0;
      for (int j = 0; j < 8; j++) begin
        xb = x[j];
        yb = divisor[j];
        if (approx_en && (j + k < `DIV_APPROX_DEPTH)) begin
          diff[j] = (xb & ~yb) | (~xb & yb & b) | (xb & yb & ~b);
          b       = yb & ~(xb & b);
        end else begin
          diff[j] = xb ^ yb ^ b;
          b       = (~xb & yb) | ((xb == yb) & b);
        end
      end
      q      = top | ~b;
      quo[k] = q;
      prem   = q ? diff : x;
    end
    return {prem, quo};
  endfunction

  task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waited;
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    waited  = 0;
    @(negedge clk);
    while (!pready) begin
      waited++;
      if (waited > APB_TIMEOUT) fail_run("APB transfer never completed");
      @(negedge clk);
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_reg(input logic [3:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, wdata, rdata, err);
    check_value("pslverr", err, 0);
  endtask

  task automatic read_reg(input logic [3:0] addr, output logic [31:0] rdata);
    logic err;
    apb_access(1'b0, addr, '0, rdata, err);
    check_value("pslverr", err, 0);
  endtask

  // holds an OPERAND write for a while, expects no pready, then backs off.
  task automatic operand_stall_probe(input logic [31:0] wdata);
    @(posedge clk);
    #2;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = `DIV_ADDR_OPERAND;
    pwdata  = wdata;
    @(posedge clk);
    #2;
    penable = 1'b1;
    repeat (STALL_CYCLES) begin
      @(negedge clk);
      if (pready) fail_run("OPERAND write completed with every credit in use");
    end
    @(posedge clk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // queues the expected result and writes OPERAND.
  task automatic launch_fixed(input logic [15:0] dividend, input logic [7:0] divisor,
                              input logic approx_en);
    exp_q.push_back(ref_divide(dividend, divisor, approx_en));
    write_reg(`DIV_ADDR_OPERAND, {8'h00, divisor, dividend});
  endtask

  // in_range keeps the quotient within 8 bits and checks against true division.
  task automatic launch_random(input logic approx_en, input logic in_range);
    logic [15:0] dividend;
    logic [7:0]  divisor;
    logic [15:0] model;
    logic [15:0] truth;
    seed     = lcg_next(seed);
    dividend = seed[31:16];
    seed     = lcg_next(seed);
    divisor  = seed[31:24];
    if (in_range) begin
      if (divisor == 8'h00) divisor = 8'h01;
      dividend[15:8] = dividend[15:8] % divisor;
    end
    model = ref_divide(dividend, divisor, approx_en);
    if (in_range) begin
      truth = {8'(dividend % divisor), 8'(dividend / divisor)};
      check_value("model_quotient", model[7:0], truth[7:0]);
      check_value("model_remainder", model[15:8], truth[15:8]);
    end
    launch_fixed(dividend, divisor, approx_en);
  endtask

  task automatic read_result();
    logic [31:0] rdata;
    read_reg(`DIV_ADDR_RESULT, rdata);
    got_q.push_back(rdata[16:0]);
  endtask

  task automatic wait_fifo_count(input int n);
    logic [31:0] st;
    int          polls;
    polls = 0;
    read_reg(`DIV_ADDR_STATUS, st);
    while (st[3:0] < n) begin
      polls++;
      if (polls > POLL_LIMIT) fail_run("FIFO never reached the expected count");
      read_reg(`DIV_ADDR_STATUS, st);
    end
  endtask

  task automatic drain(input int n);
    wait_fifo_count(n);
    repeat (n) read_result();
  endtask

  task automatic check_status_total(input int n);
    logic [31:0] st;
    read_reg(`DIV_ADDR_STATUS, st);
    check_value("status_total", 32'(st[3:0]) + 32'(st[7:4]), n);
  endtask

  task automatic wait_compare_done();
    int waited;
    waited = 0;
    while (got_q.size() != 0) begin
      waited++;
      if (waited > DRAIN_LIMIT) fail_run("results were read but never compared");
      @(posedge clk);
    end
  endtask

  always @(negedge clk) begin
    if (got_q.size() != 0) begin
      cmp_got = got_q.pop_front();
      if (exp_q.size() == 0) fail_run("RESULT returned data with nothing outstanding");
      cmp_exp = exp_q.pop_front();
      check_value("result_valid", cmp_got[16], 1);
      check_value("quotient", cmp_got[7:0], cmp_exp[7:0]);
      check_value("remainder", cmp_got[15:8], cmp_exp[15:8]);
    end
  end

  initial begin
    logic [31:0] rd;
    logic        err;
    int          approx_ops;
    int          waited;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    seed    = 32'd1021;
    waited  = 0;
    while (rst_n !== 1'b1) begin
      waited++;
      if (waited > 50) fail_run("reset never released");
      @(posedge clk);
    end

    // register access and decode errors.
    read_reg(`DIV_ADDR_CTRL, rd);
    check_value("ctrl", rd, 1);
    write_reg(`DIV_ADDR_CTRL, 0);
    read_reg(`DIV_ADDR_CTRL, rd);
    check_value("ctrl", rd, 0);
    write_reg(`DIV_ADDR_CTRL, 1);
    read_reg(`DIV_ADDR_CTRL, rd);
    check_value("ctrl", rd, 1);
    apb_access(1'b1, 4'h3, 32'h0000_0001, rd, err);
    check_value("pslverr", err, 1);
    apb_access(1'b0, 4'hE, '0, rd, err);
    check_value("pslverr", err, 1);

    // exact mode against true division.
    write_reg(`DIV_ADDR_CTRL, 0);
    for (int b = 0; b < 25; b++) begin
      repeat (8) launch_random(1'b0, 1'b1);
      drain(8);
    end

    // approximate mode with CTRL flipping while earlier ops are in the rows.
    write_reg(`DIV_ADDR_CTRL, 1);
    launch_fixed(16'hA5C3, 8'h00, 1'b1);  // zero divisor.
    launch_fixed(16'h0000, 8'h00, 1'b1);
    drain(2);
    approx_ops = 0;
    while (approx_ops < 200) begin
      repeat (6) launch_random(1'b1, 1'b0);
      approx_ops += 6;
      write_reg(`DIV_ADDR_CTRL, 0);
      repeat (2) launch_random(1'b0, 1'b0);
      write_reg(`DIV_ADDR_CTRL, 1);
      drain(8);
    end

    // credit limit and stall.
    repeat (8) launch_random(1'b1, 1'b0);
    check_status_total(8);
    wait_fifo_count(8);
    read_reg(`DIV_ADDR_STATUS, rd);
    check_value("status_fifo_count", rd[3:0], 8);
    check_value("status_in_flight", rd[7:4], 0);
    operand_stall_probe(32'h0011_2233);
    read_result();
    launch_random(1'b1, 1'b0);
    check_status_total(8);
    operand_stall_probe(32'h0044_5566);
    read_result();
    launch_random(1'b1, 1'b0);
    check_status_total(8);
    drain(8);

    // empty FIFO read.
    read_reg(`DIV_ADDR_RESULT, rd);
    check_value("result_valid", rd[16], 0);
    read_reg(`DIV_ADDR_STATUS, rd);
    check_value("status_fifo_count", rd[3:0], 0);
    check_value("status_in_flight", rd[7:4], 0);

    wait_compare_done();
    check_value("pending_results", exp_q.size(), 0);
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    repeat (400000) @(posedge clk);
    fail_run("simulation watchdog expired");
  end

endmodule

// File: approx_div_top.f
+incdir+rtl
rtl/div_pkg.sv
rtl/div_stage_if.sv
rtl/div_apb_regs.sv
rtl/div_row.sv
rtl/div_result_fifo.sv
rtl/approx_div_top.sv
dv/tb_clk_gen.sv
dv/tb_approx_div.sv
